//--- vlog.f
+incdir+hdl
hdl/mapper_pkg.sv
hdl/cart_config_regs.sv
hdl/mapper_ascii8.sv
hdl/backup_sram.sv
hdl/cart_slot_top.sv
test/tb_clock_gen.sv
test/tb_cart_slot.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the cartridge mapper testbench with Verilator and run it.
# The run counts as failed when sim.log holds the fail message.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_cart_slot \
    -o tb_cart_slot \
    && ./obj_dir/tb_cart_slot > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log

grep -q "RESULT: FAIL" sim.log \
    && { echo "Simulation reported a failure"; exit 1; } \
    || { echo "Simulation finished without failures"; exit 0; }

//--- test/cart_trace.txt
# op name addr data expected flags (all hex)
# C config write, W memory write, R memory read, S SRAM read data; flags = {ram_cs, sram_cs, rnw}
R reset_rd_4000          4000 00 7ffffff 1
C cfg0_select            0000 00 0       0
C cfg0_type_ascii8       0001 01 0       0
C cfg0_rom_32_pages      0002 20 0       0
C cfg0_sram_1_unit       0003 01 0       0
R unmapped_rd_0000       0000 00 7ffffff 1
W bank0_r1_05            6800 05 0       1
R rd_6123_bank05         6123 00 000a123 5
W bank0_r0_40            6000 40 0       1
R rd_4abc_above_rom      4abc 00 0080abc 1
W bank0_r2_0a            7000 0a 0       1
W bank0_r3_1f            7800 1f 0       1
R rd_8000_bank0a         8000 00 0014000 5
R rd_bfff_last_byte      bfff 00 003ffff 5
C cfg1_select            0000 01 0       0
C cfg1_type_ascii8       0001 01 0       0
C cfg1_rom_16_pages      0002 10 0       0
W bank1_r1_03            6800 03 0       1
R blk1_rd_6123           6123 00 0006123 5
R blk1_rd_8000           8000 00 0000000 5
C cfg0_reselect          0000 00 0       0
R blk0_rd_6123_again     6123 00 000a123 5
W sram_enable_8000       7000 20 0       1
W sram_wr_8010           8010 5a 0       2
R sram_rd_8010_sel       8010 00 0000010 3
S sram_data_8010         8010 00 5a      0
W sram_disable_8000      7000 07 0       1
R rd_8010_rom_again      8010 00 000e010 5
C cfg1_select_wiz        0000 01 0       0
C cfg1_type_wizardy      0001 03 0       0
C cfg1_sram_1_unit       0003 01 0       0
W wiz_r3_10_rom          7800 10 0       1
R wiz_rd_a000_above      a000 00 0020000 1
W wiz_r3_80_sram         7800 80 0       1
R wiz_rd_a005_sel        a005 00 0000005 3
W wiz_wr_a005            a005 c3 0       2
S wiz_data_a005          a005 00 c3      0
C cfg1_type_koei         0001 02 0       0
W koei_r0_sram           6000 10 0       1
R koei_rd_4100_sram      4100 00 0000100 3
C cfg0_select_ascii8     0000 00 0       0
W ascii8_r0_02           6000 02 0       1
W ascii8_r0_sram_refused 6000 20 0       1
R ascii8_rd_4100_rom     4100 00 0004100 5
C cfg1_select_none       0000 01 0       0
C cfg1_type_none         0001 00 0       0
W none_bank_wr           6800 09 0       1
R none_rd_6123           6123 00 7ffffff 1
C cfg1_type_ascii8_back  0001 01 0       0
R none_wr_ignored        6123 00 0006123 5

//--- test/tb_cart_slot.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cart_slot;

    import mapper_pkg::*;

    localparam int    CLK_PERIOD_NS   = 100;
    localparam int    RESET_CYCLES    = 10;
    localparam int    DRIVE_DELAY_NS  = 5;
    localparam int    CYCLES_PER_LINE = 4;
    localparam string TRACE_FILE      = "test/cart_trace.txt";

    logic        cpu_bus;
    logic        reset;
    cpu_req_t    req;
    mapper_out_t out;
    logic [7:0]  sram_rdata;

    // Trace lines, one entry per operation
    string       op_q[$];
    string       name_q[$];
    logic [15:0] addr_q[$];
    logic [7:0]  data_q[$];
    logic [31:0] exp_q[$];
    logic [2:0]  flags_q[$];

    int          trace_len;
    int          pass_count;
    int          fail_count;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .cpu_bus (cpu_bus),
        .reset   (reset)
    );

    cart_slot_top dut (
        .cpu_bus    (cpu_bus),
        .reset      (reset),
        .req        (req),
        .out        (out),
        .sram_rdata (sram_rdata)
    );

    task automatic load_trace(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       op;
        string       name;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_val;
        logic [31:0] flags;
        ok = 1'b1;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open trace file %s", TRACE_FILE);
            ok = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Skip comments and blank lines
                if (line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%s %s %h %h %h %h", op, name, addr, data, exp_val, flags);
                if (n != 6) begin
                    $display("Malformed trace line: %s", line);
                    ok = 1'b0;
                end else if (op != "C" && op != "W" && op != "R" && op != "S") begin
                    $display("Unknown operation %s in trace line of %s", op, name);
                    ok = 1'b0;
                end else begin
                    op_q.push_back(op);
                    name_q.push_back(name);
                    addr_q.push_back(addr[15:0]);
                    data_q.push_back(data[7:0]);
                    exp_q.push_back(exp_val);
                    flags_q.push_back(flags[2:0]);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_idle();
        req = '0;
    endtask

    task automatic drive_config(input logic [1:0] index, input logic [7:0] value);
        req              = '0;
        req.addr         = {14'h0000, index};
        req.data         = value;
        req.wr           = 1'b1;
        req.iorq         = 1'b1;
        req.io_wr_strobe = 1'b1;
    endtask

    task automatic drive_mem(input logic [15:0] addr, input logic [7:0] data,
                             input logic rd, input logic wr);
        req      = '0;
        req.addr = addr;
        req.data = data;
        req.rd   = rd;
        req.wr   = wr;
        req.mreq = 1'b1;
    endtask

    task automatic report_pass(input string name);
        pass_count++;
        $display("PASS %s", name);
    endtask

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        fail_count++;
        $display("[FAIL] %s %s expected %0h actual %0h", name, field, expected, actual);
    endtask

    task automatic run_line(input int i);
        logic [2:0] act_flags;
        @(posedge cpu_bus);
        #(DRIVE_DELAY_NS);
        if (op_q[i] == "C") begin
            drive_config(addr_q[i][1:0], data_q[i]);
        end else if (op_q[i] == "W") begin
            drive_mem(addr_q[i], data_q[i], 1'b0, 1'b1);
        end else begin
            drive_mem(addr_q[i], 8'h00, 1'b1, 1'b0);
        end

        // Mapper outputs are combinational, settled by mid cycle
        @(negedge cpu_bus);
        act_flags = {out.ram_cs, out.sram_cs, out.rnw};
        if (op_q[i] == "R") begin
            if (out.addr !== exp_q[i][26:0]) begin
                report_mismatch(name_q[i], "addr", exp_q[i], {5'b0, out.addr});
            end else if (act_flags !== flags_q[i]) begin
                report_mismatch(name_q[i], "ram_cs/sram_cs/rnw",
                                {29'b0, flags_q[i]}, {29'b0, act_flags});
            end else begin
                report_pass(name_q[i]);
            end
        end else if (op_q[i] == "W") begin
            if (act_flags !== flags_q[i]) begin
                report_mismatch(name_q[i], "ram_cs/sram_cs/rnw",
                                {29'b0, flags_q[i]}, {29'b0, act_flags});
            end else begin
                report_pass(name_q[i]);
            end
        end else if (op_q[i] == "S") begin
            // Read data is registered on the next edge
            @(posedge cpu_bus);
            #(DRIVE_DELAY_NS);
            drive_idle();
            @(negedge cpu_bus);
            if (sram_rdata !== exp_q[i][7:0]) begin
                report_mismatch(name_q[i], "sram_rdata", exp_q[i], {24'b0, sram_rdata});
            end else begin
                report_pass(name_q[i]);
            end
        end
    endtask

    initial begin : main
        bit loaded;
        req        = '0;
        pass_count = 0;
        fail_count = 0;
        load_trace(loaded);
        if (!loaded || op_q.size() == 0) begin
            $display("Trace could not be loaded, no tests were run");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            trace_len = op_q.size();
            @(negedge reset);
            for (int i = 0; i < trace_len; i++) begin
                run_line(i);
            end
            @(posedge cpu_bus);
            #(DRIVE_DELAY_NS);
            drive_idle();
            $display("Tests run %0d, passed %0d, failed %0d",
                     pass_count + fail_count, pass_count, fail_count);
            if (fail_count == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

    // Budget of a few cycles per trace line on top of reset
    initial begin : watchdog
        longint limit_ns;
        wait (trace_len > 0);
        limit_ns = (longint'(trace_len) * CYCLES_PER_LINE + RESET_CYCLES) * CLK_PERIOD_NS;
        #(limit_ns);
        $display("Timeout, the trace did not finish within %0d ns", limit_ns);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic cpu_bus,
    output logic reset
);

    initial begin
        cpu_bus = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            cpu_bus = ~cpu_bus;
        end
    end

    // Release lines up with the stimulus delay after an edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge cpu_bus);
        #5;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/cart_slot_top.sv
`timescale 1ns/100ps
`default_nettype none

module cart_slot_top (
    input  logic                    cpu_bus,
    input  logic                    reset,
    input  mapper_pkg::cpu_req_t    req,
    output mapper_pkg::mapper_out_t out,
    output logic [7:0]              sram_rdata
);

    import mapper_pkg::*;

    // Configuration of the active block
    block_info_t block_info;

    // I/O mapped type and size registers
    cart_config_regs u_config (
        .cpu_bus    (cpu_bus),
        .reset      (reset),
        .req        (req),
        .block_info (block_info)
    );

    // Bank registers and address translation
    mapper_ascii8 u_mapper (
        .cpu_bus    (cpu_bus),
        .reset      (reset),
        .req        (req),
        .block_info (block_info),
        .out        (out)
    );

    // Backup SRAM answers cycles that the mapper sends to SRAM
    backup_sram u_sram (
        .cpu_bus    (cpu_bus),
        .reset      (reset),
        .out        (out),
        .wdata      (req.data),
        .rdata      (sram_rdata)
    );

endmodule

`default_nettype wire

//--- hdl/backup_sram.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_consts.svh"

module backup_sram (
    input  logic                    cpu_bus,
    input  logic                    reset,
    input  mapper_pkg::mapper_out_t out,
    input  logic [7:0]              wdata,
    output logic [7:0]              rdata
);

    import mapper_pkg::*;

    localparam int DEPTH = 2 ** `MAPPER_SRAM_ADDR_W;

    logic [7:0]                    mem [DEPTH];
    logic [`MAPPER_SRAM_ADDR_W-1:0] sram_addr;
    logic                          sram_wr;
    logic                          sram_rd;

    assign sram_addr = out.addr[`MAPPER_SRAM_ADDR_W-1:0];
    assign sram_wr   = out.sram_cs & ~out.rnw;
    assign sram_rd   = out.sram_cs & out.rnw;

    // Byte array, no reset
    always_ff @(posedge cpu_bus) begin
        if (sram_wr) begin
            mem[sram_addr] <= wdata;
        end
    end

    // Read data follows the select by one cycle
    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            rdata <= '0;
        end else if (sram_rd) begin
            rdata <= mem[sram_addr];
        end
    end

    // Mapper SRAM banks must stay inside the 32 KB array
    a_sram_range: assert property (@(posedge cpu_bus) disable iff (reset)
        out.sram_cs |-> (out.addr[`MAPPER_ADDR_W-1:`MAPPER_SRAM_ADDR_W] == '0));

endmodule

`default_nettype wire

//--- hdl/mapper_ascii8.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_consts.svh"

module mapper_ascii8 (
    input  logic                    cpu_bus,
    input  logic                    reset,
    input  mapper_pkg::cpu_req_t    req,
    input  mapper_pkg::block_info_t block_info,
    output mapper_pkg::mapper_out_t out
);

    import mapper_pkg::*;

    logic                       mapped;
    logic                       mapper_en;
    logic                       mode_koei;
    logic                       mode_wizardy;
    logic                       cs;
    logic                       bank_wr;

    logic                       sram_exists;
    logic [`MAPPER_BANK_W-1:0]  sram_units;
    logic [`MAPPER_BANK_W-1:0]  sram_mask;
    logic [`MAPPER_BANK_W-1:0]  sram_en_bit;
    logic [7:0]                 sram_pages;
    logic [1:0]                 region;
    logic [7:0]                 region_bit;
    logic [1:0]                 window;

    // Bank registers, kept separately for each block
    logic [`MAPPER_BANK_W-1:0]  bank      [`MAPPER_BLOCKS][4];
    logic [`MAPPER_BANK_W-1:0]  sram_bank [`MAPPER_BLOCKS][4];
    // One bit per 8 KB page of the 64 KB space, indexed by addr[15:13]
    logic [7:0]                 sram_enable[`MAPPER_BLOCKS];

    logic                       sram_en;
    logic [`MAPPER_ADDR_W-1:0]  rom_addr;
    logic [`MAPPER_ADDR_W-1:0]  sram_addr;
    logic                       rom_valid;
    logic                       ram_cs;
    logic                       sram_cs;

    // Only 4000h to BFFFh is mapped
    assign mapped       = ^req.addr[15:14];
    assign mapper_en    = block_info.typ inside {MAPPER_ASCII8, MAPPER_KOEI, MAPPER_WIZARDY};
    assign mode_koei    = (block_info.typ == MAPPER_KOEI);
    assign mode_wizardy = (block_info.typ == MAPPER_WIZARDY);
    assign cs           = mapped & mapper_en & req.mreq;

    // Bank switch window is 6000h to 7FFFh
    assign bank_wr      = cs & req.wr & (req.addr[15:13] == 3'b011);

    assign sram_exists  = (block_info.sram_size != '0);
    assign sram_units   = block_info.sram_size[10:3];
    assign sram_mask    = (sram_units != '0) ? sram_units - 1'b1 : '0;

    // WIZARDY uses bit 7, the others use the bit just above the ROM pages
    assign sram_en_bit  = mode_wizardy ? 8'h80 : block_info.rom_size[20:`MAPPER_PAGE_W];
    // KOEI may also put SRAM at 4000h
    assign sram_pages   = mode_koei ? 8'h34 : 8'h30;

    assign region       = req.addr[12:11];
    assign region_bit   = 8'b0000_0100 << region;
    assign window       = {req.addr[15], req.addr[13]};

    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            for (int b = 0; b < `MAPPER_BLOCKS; b++) begin
                sram_enable[b] <= '0;
                for (int r = 0; r < 4; r++) begin
                    bank[b][r]      <= '0;
                    sram_bank[b][r] <= '0;
                end
            end
        end else if (bank_wr) begin
            if (((req.data & sram_en_bit) != '0) && sram_exists) begin
                sram_enable[block_info.id] <= sram_enable[block_info.id] |
                                              (region_bit & sram_pages);
                sram_bank[block_info.id][region] <= req.data & sram_mask;
            end else begin
                sram_enable[block_info.id] <= sram_enable[block_info.id] & ~region_bit;
                bank[block_info.id][region] <= req.data;
            end
        end
    end

    // Translation into the flat address space
    assign sram_en   = |((8'b0000_0001 << req.addr[15:13]) & sram_enable[block_info.id]);
    assign rom_addr  = {{(`MAPPER_ADDR_W - `MAPPER_BANK_W - `MAPPER_PAGE_W){1'b0}},
                        bank[block_info.id][window], req.addr[`MAPPER_PAGE_W-1:0]};
    assign sram_addr = {{(`MAPPER_ADDR_W - `MAPPER_BANK_W - `MAPPER_PAGE_W){1'b0}},
                        sram_bank[block_info.id][window], req.addr[`MAPPER_PAGE_W-1:0]};
    assign rom_valid = (rom_addr < {{(`MAPPER_ADDR_W - 21){1'b0}}, block_info.rom_size});

    assign sram_cs   = cs & sram_en;
    assign ram_cs    = cs & rom_valid & ~sram_en & req.rd;

    assign out.ram_cs  = ram_cs;
    assign out.sram_cs = sram_cs;
    assign out.rnw     = ~(sram_cs & req.wr);
    assign out.addr    = cs ? (sram_en ? sram_addr : rom_addr) : {`MAPPER_ADDR_W{1'b1}};

    a_cs_exclusive: assert property (@(posedge cpu_bus) disable iff (reset)
        !(out.ram_cs && out.sram_cs));

    a_idle_addr: assert property (@(posedge cpu_bus) disable iff (reset)
        (!out.ram_cs && !out.sram_cs && !mapped) |-> (&out.addr));

endmodule

`default_nettype wire

//--- hdl/cart_config_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_consts.svh"

module cart_config_regs (
    input  logic                    cpu_bus,
    input  logic                    reset,
    input  mapper_pkg::cpu_req_t    req,
    output mapper_pkg::block_info_t block_info
);

    import mapper_pkg::*;

    // Per block configuration
    mapper_typ_t                blk_typ   [`MAPPER_BLOCKS];
    logic [`MAPPER_BANK_W-1:0]  rom_pages [`MAPPER_BLOCKS];
    logic [7:0]                 sram_units[`MAPPER_BLOCKS];

    // Active block, also the target of type and size writes
    logic                       active_id;

    always_ff @(posedge cpu_bus) begin
        if (reset) begin
            active_id <= 1'b0;
            for (int b = 0; b < `MAPPER_BLOCKS; b++) begin
                blk_typ[b]    <= MAPPER_NONE;
                rom_pages[b]  <= '0;
                sram_units[b] <= '0;
            end
        end else if (req.io_wr_strobe) begin
            case (req.addr[1:0])
                `CFG_REG_SELECT: begin
                    active_id <= req.data[0];
                end
                `CFG_REG_TYPE: begin
                    blk_typ[active_id] <= mapper_typ_t'(req.data[2:0]);
                end
                `CFG_REG_ROM_PAGES: begin
                    rom_pages[active_id] <= req.data;
                end
                `CFG_REG_SRAM_UNITS: begin
                    sram_units[active_id] <= req.data;
                end
                default: begin
                end
            endcase
        end
    end

    // Pages of 8 KB become bytes, units of 8 KB become KB
    always_comb begin
        block_info.typ       = blk_typ[active_id];
        block_info.id        = active_id;
        block_info.rom_size  = {rom_pages[active_id], {`MAPPER_PAGE_W{1'b0}}};
        block_info.sram_size = {sram_units[active_id], 3'b000};
        block_info.rsvd      = 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/mapper_pkg.sv
`default_nettype none

`include "mapper_consts.svh"

package mapper_pkg;

    // Cartridge mapper family handled by this core
    typedef enum logic [2:0] {
        MAPPER_NONE    = 3'd0,
        MAPPER_ASCII8  = 3'd1,
        MAPPER_KOEI    = 3'd2,
        MAPPER_WIZARDY = 3'd3
    } mapper_typ_t;

    // CPU side of one bus cycle
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rd;
        logic        wr;
        logic        mreq;
        logic        iorq;
        logic        io_wr_strobe;   // one cycle pulse on a config write
    } cpu_req_t;

    // Description of the active cartridge block
    typedef struct packed {
        mapper_typ_t typ;
        logic        id;
        logic [20:0] rom_size;       // bytes
        logic [10:0] sram_size;      // KB
        logic        rsvd;
    } block_info_t;

    // Translated access towards ROM and SRAM
    typedef struct packed {
        logic [`MAPPER_ADDR_W-1:0] addr;
        logic                      ram_cs;
        logic                      sram_cs;
        logic                      rnw;
    } mapper_out_t;

endpackage

`default_nettype wire

//--- hdl/mapper_consts.svh
`ifndef MAPPER_CONSTS_SVH
`define MAPPER_CONSTS_SVH

// Flat memory address driven towards ROM and SRAM
`define MAPPER_ADDR_W       27

// Number of cartridge blocks with their own bank registers
`define MAPPER_BLOCKS       2

// Backup SRAM is 32 KB
`define MAPPER_SRAM_ADDR_W  15

// 8 KB pages, bank numbers are one byte
`define MAPPER_PAGE_W       13
`define MAPPER_BANK_W       8

// Configuration register index, taken from addr[1:0] of an I/O write
`define CFG_REG_SELECT      2'd0
`define CFG_REG_TYPE        2'd1
`define CFG_REG_ROM_PAGES   2'd2
`define CFG_REG_SRAM_UNITS  2'd3

`endif
